/* Makefile */
VERILATOR  ?= verilator
FLAGS      ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only --timing
TOP        ?= decode_stage_tb
FILELIST   ?= all.f
LOG        ?= sim.log
OBJ_DIR    ?= obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^TB PASSED$$" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* all.f */
design/rv_isa_pkg.sv
design/pipe_cfg_pkg.sv
design/decode_ctrl_if.sv
design/control_unit.sv
design/operand_select.sv
design/wb_conflict_tracker.sv
design/dispatch_reg.sv
design/decode_stage.sv
verif/clk_gen.sv
verif/decode_stage_tb.sv

/* design/control_unit.sv */
// Combinational decode of OP, OP-IMM, LUI, AUIPC, loads, stores and RV32M.
// MULHSU is reported as signed; the multiplier sorts out the mixed case.
module control_unit
  import rv_isa_pkg::*;
  import pipe_cfg_pkg::*;
(
  decode_ctrl_if.cu ctrl,
  input instr_u     instr
);

  function automatic alu_op_t alu_decode(input logic [2:0] f3, input logic alt);
    alu_op_t op;
    case (f3)
      f3_add_sub: op = alt ? ALU_SUB : ALU_ADD;
      f3_sll:     op = ALU_SLL;
      f3_slt:     op = ALU_SLT;
      f3_sltu:    op = ALU_SLTU;
      f3_xor:     op = ALU_XOR;
      f3_srl_sra: op = alt ? ALU_SRA : ALU_SRL;
      f3_or:      op = ALU_OR;
      default:    op = ALU_AND;
    endcase
    return op;
  endfunction

  always_comb begin
    // defaults describe an illegal op on the ALU path
    ctrl.fu        = FU_ALU;
    ctrl.alu_op    = ALU_ADD;
    ctrl.rs1       = instr.r.rs1;
    ctrl.rs2       = instr.r.rs2;
    ctrl.rd        = instr.r.rd;
    ctrl.wen       = 1'b0;
    ctrl.src_a     = SRC_A_RS1;
    ctrl.src_b     = SRC_B_RS2;
    ctrl.is_store  = 1'b0;
    ctrl.is_load   = 1'b0;
    ctrl.mul_high  = 1'b0;
    ctrl.div_rem   = 1'b0;
    ctrl.is_signed = 1'b0;
    ctrl.illegal   = 1'b0;

    case (instr.r.opcode)
      OP: begin
        if (instr.r.funct7 == funct7_muldiv) begin
          ctrl.wen       = 1'b1;
          ctrl.fu        = instr.r.funct3[2] ? FU_DIV : FU_MUL;
          ctrl.mul_high  = !instr.r.funct3[2] && (instr.r.funct3 != 3'd0);
          ctrl.div_rem   = instr.r.funct3[2] && instr.r.funct3[1];
          ctrl.is_signed = instr.r.funct3[2] ? !instr.r.funct3[0] : (instr.r.funct3 != 3'd3);
        end else if (instr.r.funct7 == funct7_base ||
                     (instr.r.funct7 == funct7_alt &&
                      (instr.r.funct3 == f3_add_sub || instr.r.funct3 == f3_srl_sra))) begin
          ctrl.wen    = 1'b1;
          ctrl.alu_op = alu_decode(instr.r.funct3, instr.r.funct7[5]);
        end else begin
          ctrl.illegal = 1'b1;
        end
      end
      OP_IMM: begin
        ctrl.src_b = SRC_B_IMM_I;
        // shift immediates keep funct7 in imm[11:5]
        if ((instr.r.funct3 == f3_sll && instr.r.funct7 != funct7_base) ||
            (instr.r.funct3 == f3_srl_sra && instr.r.funct7 != funct7_base &&
             instr.r.funct7 != funct7_alt)) begin
          ctrl.illegal = 1'b1;
        end else begin
          ctrl.wen    = 1'b1;
          ctrl.alu_op = alu_decode(instr.r.funct3,
                                   instr.r.funct3 == f3_srl_sra && instr.r.funct7[5]);
        end
      end
      LUI: begin
        ctrl.wen   = 1'b1;
        ctrl.src_a = SRC_A_ZERO;
        ctrl.src_b = SRC_B_IMM_U;
      end
      AUIPC: begin
        ctrl.wen   = 1'b1;
        ctrl.src_a = SRC_A_PC;
        ctrl.src_b = SRC_B_IMM_U;
      end
      LOAD: begin
        if (instr.i.funct3 == 3'd3 || instr.i.funct3[2:1] == 2'b11) begin
          ctrl.illegal = 1'b1;
        end else begin
          ctrl.fu        = FU_LSU;
          ctrl.wen       = 1'b1;
          ctrl.is_load   = 1'b1;
          ctrl.src_b     = SRC_B_IMM_I;
          // LB and LH sign extend, LBU and LHU do not
          ctrl.is_signed = !instr.i.funct3[2];
        end
      end
      STORE: begin
        if (instr.s.funct3 > 3'd2) begin
          ctrl.illegal = 1'b1;
        end else begin
          ctrl.fu       = FU_LSU;
          ctrl.is_store = 1'b1;
          ctrl.src_b    = SRC_B_IMM_S;
          ctrl.rd       = '0;
        end
      end
      default: ctrl.illegal = 1'b1;
    endcase
  end

endmodule

/* design/decode_ctrl_if.sv */
// Decoded control of the instruction currently offered by fetch.
// Driven only by the control unit; all other users read it.
interface decode_ctrl_if
  import rv_isa_pkg::*;
  import pipe_cfg_pkg::*;
();

  fu_t                   fu;
  alu_op_t               alu_op;
  logic [reg_addr_w-1:0] rs1;
  logic [reg_addr_w-1:0] rs2;
  logic [reg_addr_w-1:0] rd;
  logic                  wen;
  src_a_t                src_a;
  src_b_t                src_b;
  logic                  is_store;
  logic                  is_load;
  logic                  mul_high;
  logic                  div_rem;
  logic                  is_signed;
  logic                  illegal;

  modport cu (
    output fu, alu_op, rs1, rs2, rd, wen, src_a, src_b,
           is_store, is_load, mul_high, div_rem, is_signed, illegal
  );

  modport sel (input src_a, src_b);

  modport trk (input fu);

  modport disp (
    input fu, alu_op, rd, wen, is_store, is_load,
          mul_high, div_rem, is_signed, illegal
  );

endinterface

/* design/decode_stage.sv */
// Decode stage top: fetch handshake in, one dispatch register out.
// Register file reads are combinational; flush does not clear the tracker.
module decode_stage
  import rv_isa_pkg::*;
  import pipe_cfg_pkg::*;
(
  input  logic                  CLK,
  input  logic                  nRST,
  input  logic                  in_valid,
  output logic                  in_ready,
  input  logic [word_w-1:0]     in_instr,
  input  logic [word_w-1:0]     in_pc,
  output logic [reg_addr_w-1:0] rs1_addr,
  output logic [reg_addr_w-1:0] rs2_addr,
  input  logic [word_w-1:0]     rs1_data,
  input  logic [word_w-1:0]     rs2_data,
  input  logic                  rs1_byp_en,
  input  logic [word_w-1:0]     rs1_byp_data,
  input  logic                  rs2_byp_en,
  input  logic [word_w-1:0]     rs2_byp_data,
  input  logic                  flush,
  output logic                  out_valid,
  input  logic                  out_ready,
  output fu_t                   out_fu,
  output alu_op_t               out_alu_op,
  output logic [reg_addr_w-1:0] out_rd,
  output logic                  out_wen,
  output logic                  out_mul_high,
  output logic                  out_div_rem,
  output logic                  out_signed,
  output logic                  out_illegal,
  output logic [word_w-1:0]     out_port_a,
  output logic [word_w-1:0]     out_port_b,
  output logic [word_w-1:0]     out_store_data,
  output logic [word_w-1:0]     out_pc
);

  instr_u            instr;
  logic [word_w-1:0] port_a;
  logic [word_w-1:0] port_b;
  logic [word_w-1:0] store_data;
  logic              div_fast;
  logic              conflict;
  logic              free;
  logic              accept;

  decode_ctrl_if ctrl ();

  assign instr    = in_instr;
  assign rs1_addr = ctrl.rs1;
  assign rs2_addr = ctrl.rs2;

  // take a new op only when its writeback slot and the output are free
  assign in_ready = !conflict && free && !flush;
  assign accept   = in_valid && in_ready;

  control_unit u_cu (
    .ctrl  (ctrl),
    .instr (instr)
  );

  operand_select u_sel (
    .ctrl(ctrl), .instr(instr), .pc(in_pc),
    .rs1_data(rs1_data), .rs2_data(rs2_data),
    .rs1_byp_en(rs1_byp_en), .rs1_byp_data(rs1_byp_data),
    .rs2_byp_en(rs2_byp_en), .rs2_byp_data(rs2_byp_data),
    .port_a(port_a), .port_b(port_b), .store_data(store_data), .div_fast(div_fast)
  );

  wb_conflict_tracker u_trk (
    .CLK(CLK), .nRST(nRST), .ctrl(ctrl),
    .accept(accept), .div_fast(div_fast), .conflict(conflict)
  );

  dispatch_reg u_disp (
    .CLK(CLK), .nRST(nRST), .ctrl(ctrl),
    .port_a(port_a), .port_b(port_b), .store_data(store_data), .pc(in_pc),
    .load(accept), .flush(flush), .out_ready(out_ready), .free(free),
    .out_valid(out_valid), .out_fu(out_fu), .out_alu_op(out_alu_op), .out_rd(out_rd),
    .out_wen(out_wen), .out_mul_high(out_mul_high), .out_div_rem(out_div_rem),
    .out_signed(out_signed), .out_illegal(out_illegal),
    .out_port_a(out_port_a), .out_port_b(out_port_b),
    .out_store_data(out_store_data), .out_pc(out_pc)
  );

endmodule

/* design/dispatch_reg.sv */
// Decode/execute pipeline register with valid/ready on the execute side.
// Only out_valid is reset; payload fields are undefined until the first load.
module dispatch_reg
  import rv_isa_pkg::*;
  import pipe_cfg_pkg::*;
(
  input  logic                  CLK,
  input  logic                  nRST,
  decode_ctrl_if.disp           ctrl,
  input  logic [word_w-1:0]     port_a,
  input  logic [word_w-1:0]     port_b,
  input  logic [word_w-1:0]     store_data,
  input  logic [word_w-1:0]     pc,
  input  logic                  load,
  input  logic                  flush,
  input  logic                  out_ready,
  output logic                  free,
  output logic                  out_valid,
  output fu_t                   out_fu,
  output alu_op_t               out_alu_op,
  output logic [reg_addr_w-1:0] out_rd,
  output logic                  out_wen,
  output logic                  out_mul_high,
  output logic                  out_div_rem,
  output logic                  out_signed,
  output logic                  out_illegal,
  output logic [word_w-1:0]     out_port_a,
  output logic [word_w-1:0]     out_port_b,
  output logic [word_w-1:0]     out_store_data,
  output logic [word_w-1:0]     out_pc
);

  assign free = !out_valid || out_ready;

  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      out_valid <= 1'b0;
    end else if (flush) begin
      out_valid <= 1'b0;
    end else if (load) begin
      out_valid <= 1'b1;
    end else if (out_ready) begin
      out_valid <= 1'b0;
    end
  end

  always_ff @(posedge CLK) begin
    if (load) begin
      out_fu         <= ctrl.fu;
      out_alu_op     <= ctrl.alu_op;
      out_rd         <= ctrl.rd;
      out_wen        <= ctrl.wen;
      out_mul_high   <= ctrl.mul_high;
      out_div_rem    <= ctrl.div_rem;
      out_signed     <= ctrl.is_signed;
      out_illegal    <= ctrl.illegal;
      out_port_a     <= port_a;
      out_port_b     <= port_b;
      // store data is only meaningful for stores
      out_store_data <= ctrl.is_store ? store_data : '0;
      out_pc         <= pc;
    end
  end

  a_hold_payload: assert property (
    @(posedge CLK) disable iff (!nRST)
    out_valid && !out_ready |=> $stable({out_fu, out_alu_op, out_rd, out_wen,
                                         out_mul_high, out_div_rem, out_signed,
                                         out_illegal, out_port_a, out_port_b,
                                         out_store_data, out_pc})
  );

endmodule

/* design/operand_select.sv */
// Immediate extension, bypass muxing and operand selection.
// Purely combinational; bypass data always wins over the register file.
module operand_select
  import rv_isa_pkg::*;
  import pipe_cfg_pkg::*;
(
  decode_ctrl_if.sel        ctrl,
  input  instr_u            instr,
  input  logic [word_w-1:0] pc,
  input  logic [word_w-1:0] rs1_data,
  input  logic [word_w-1:0] rs2_data,
  input  logic              rs1_byp_en,
  input  logic [word_w-1:0] rs1_byp_data,
  input  logic              rs2_byp_en,
  input  logic [word_w-1:0] rs2_byp_data,
  output logic [word_w-1:0] port_a,
  output logic [word_w-1:0] port_b,
  output logic [word_w-1:0] store_data,
  output logic              div_fast
);

  logic [word_w-1:0] imm_i;
  logic [word_w-1:0] imm_s;
  logic [word_w-1:0] imm_u;
  logic [word_w-1:0] rs1_val;
  logic [word_w-1:0] rs2_val;

  assign imm_i = {{(word_w-12){instr.i.imm12[11]}}, instr.i.imm12};
  assign imm_s = {{(word_w-12){instr.s.imm_hi[6]}}, instr.s.imm_hi, instr.s.imm_lo};
  assign imm_u = {instr.u.imm20, {(word_w-20){1'b0}}};

  assign rs1_val = rs1_byp_en ? rs1_byp_data : rs1_data;
  assign rs2_val = rs2_byp_en ? rs2_byp_data : rs2_data;

  always_comb begin
    case (ctrl.src_a)
      SRC_A_RS1: port_a = rs1_val;
      SRC_A_PC:  port_a = pc;
      default:   port_a = '0;
    endcase
  end

  always_comb begin
    case (ctrl.src_b)
      SRC_B_RS2:   port_b = rs2_val;
      SRC_B_IMM_I: port_b = imm_i;
      SRC_B_IMM_S: port_b = imm_s;
      default:     port_b = imm_u;
    endcase
  end

  assign store_data = rs2_val;

  // divider finishes early on these corner cases
  assign div_fast = (port_a == {1'b1, {(word_w-1){1'b0}}}) ||
                    (port_b == '1) || (port_b == '0);

endmodule

/* design/pipe_cfg_pkg.sv */
// Pipeline widths, unit codes and writeback latencies.
// The reservation window must cover the longest fixed latency.
package pipe_cfg_pkg;

  localparam int word_w     = 32;
  localparam int reg_addr_w = 5;

  typedef enum logic [1:0] {
    FU_ALU, FU_MUL, FU_DIV, FU_LSU
  } fu_t;

  typedef enum logic [1:0] {
    SRC_A_RS1, SRC_A_PC, SRC_A_ZERO
  } src_a_t;

  typedef enum logic [1:0] {
    SRC_B_RS2, SRC_B_IMM_I, SRC_B_IMM_S, SRC_B_IMM_U
  } src_b_t;

  // cycles from accept to writeback
  localparam int lat_alu      = 1;
  localparam int lat_mul      = 4;
  localparam int lat_div      = 18;
  // divide by zero, by -1 or of the most negative word
  localparam int lat_div_fast = 1;

  localparam int wb_window = lat_div;

endpackage

/* design/rv_isa_pkg.sv */
// RV32I register/immediate and load/store encodings plus the M extension.
// Only the opcodes that the decode stage supports are listed here.
package rv_isa_pkg;

  // major opcodes
  typedef enum logic [6:0] {
    OP     = 7'b0110011,
    OP_IMM = 7'b0010011,
    LUI    = 7'b0110111,
    AUIPC  = 7'b0010111,
    LOAD   = 7'b0000011,
    STORE  = 7'b0100011
  } opcode_t;

  // funct3 for OP and OP-IMM
  localparam logic [2:0] f3_add_sub = 3'd0;
  localparam logic [2:0] f3_sll     = 3'd1;
  localparam logic [2:0] f3_slt     = 3'd2;
  localparam logic [2:0] f3_sltu    = 3'd3;
  localparam logic [2:0] f3_xor     = 3'd4;
  localparam logic [2:0] f3_srl_sra = 3'd5;
  localparam logic [2:0] f3_or      = 3'd6;
  localparam logic [2:0] f3_and     = 3'd7;

  localparam logic [6:0] funct7_base   = 7'b0000000;
  localparam logic [6:0] funct7_alt    = 7'b0100000;
  localparam logic [6:0] funct7_muldiv = 7'b0000001;

  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
    ALU_SLL, ALU_SRL, ALU_SRA, ALU_SLT, ALU_SLTU
  } alu_op_t;

  // one instruction word, four format views
  typedef union packed {
    struct packed {
      logic [6:0] funct7;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] rd;
      logic [6:0] opcode;
    } r;
    struct packed {
      logic [11:0] imm12;
      logic [4:0]  rs1;
      logic [2:0]  funct3;
      logic [4:0]  rd;
      logic [6:0]  opcode;
    } i;
    struct packed {
      logic [6:0] imm_hi;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] imm_lo;
      logic [6:0] opcode;
    } s;
    struct packed {
      logic [19:0] imm20;
      logic [4:0]  rd;
      logic [6:0]  opcode;
    } u;
  } instr_u;

endpackage

/* design/wb_conflict_tracker.sv */
// Tracks future use of the shared writeback port, one bit per cycle ahead.
// Loads and stores reserve nothing, their latency is not fixed.
module wb_conflict_tracker
  import pipe_cfg_pkg::*;
(
  input  logic        CLK,
  input  logic        nRST,
  decode_ctrl_if.trk  ctrl,
  input  logic        accept,
  input  logic        div_fast,
  output logic        conflict
);

  logic [wb_window-1:0] resv;
  logic [wb_window-1:0] slot;

  // slot for latency L sits at bit L-1
  always_comb begin
    slot = '0;
    case (ctrl.fu)
      FU_ALU: slot[lat_alu-1] = 1'b1;
      FU_MUL: slot[lat_mul-1] = 1'b1;
      FU_DIV: begin
        if (div_fast) begin
          slot[lat_div_fast-1] = 1'b1;
        end else begin
          slot[lat_div-1] = 1'b1;
        end
      end
      default: slot = '0;
    endcase
  end

  assign conflict = |(resv & slot);

  // claim the slot, then age everything by one cycle
  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      resv <= '0;
    end else if (accept) begin
      resv <= (resv | slot) >> 1;
    end else begin
      resv <= resv >> 1;
    end
  end

  // handshake logic at the top must never let a colliding op through
  a_no_double_wb: assert property (
    @(posedge CLK) disable iff (!nRST)
    accept |-> (resv & slot) == '0
  );

endmodule

/* verif/clk_gen.sv */
// Testbench clock with a period of 100 time units.
// nRST is held low for the first 4 rising edges.
module clk_gen (
  output logic CLK,
  output logic nRST
);

  initial begin
    CLK = 1'b0;
    forever #50 CLK = ~CLK;
  end

  initial begin
    nRST = 1'b0;
    repeat (4) @(posedge CLK);
    nRST <= 1'b1;
  end

endmodule

/* verif/decode_stage_tb.sv */
// Table-driven testbench for the decode stage.
// Inputs change on the rising edge, all checks run on the falling edge.
// Expected decode fields sit in the table; operands and slots come from the model.
module decode_stage_tb
  import rv_isa_pkg::*;
  import pipe_cfg_pkg::*;
;

  localparam int max_ent   = 32;
  localparam int wait_limit = 60;

  logic CLK;
  logic nRST;
  logic in_valid, in_ready, flush, out_valid, out_ready;
  logic [31:0] in_instr, in_pc, rs1_data, rs2_data, rs1_byp_data, rs2_byp_data;
  logic rs1_byp_en, rs2_byp_en;
  logic [4:0] rs1_addr, rs2_addr, out_rd;
  fu_t out_fu;
  alu_op_t out_alu_op;
  logic out_wen, out_mul_high, out_div_rem, out_signed, out_illegal;
  logic [31:0] out_port_a, out_port_b, out_store_data, out_pc;

  // stimulus and expected values
  string       t_name  [max_ent];
  logic [31:0] t_instr [max_ent];
  logic [31:0] t_pc    [max_ent];
  logic [31:0] t_rs1   [max_ent];
  logic [31:0] t_rs2   [max_ent];
  logic [31:0] t_b1    [max_ent];
  logic [31:0] t_b2    [max_ent];
  logic        t_b1en  [max_ent];
  logic        t_b2en  [max_ent];
  int          t_stall [max_ent];
  logic        t_flush [max_ent];
  fu_t         t_fu    [max_ent];
  alu_op_t     t_op    [max_ent];
  logic        t_wen   [max_ent];
  logic        t_ill   [max_ent];
  // mul_high, div_rem, signed
  logic [2:0]  t_misc  [max_ent];
  int          n_ent;

  // model state
  logic [wb_window-1:0] m_resv;
  logic                 m_valid;
  int                   sb[$];
  int                   cur;
  int                   hold_cnt;
  int                   err_val;
  int                   err_other;
  int                   transfers;
  bit                   timed_out;
  integer               seed;

  clk_gen u_clk (.CLK(CLK), .nRST(nRST));

  decode_stage DUT (
    .CLK(CLK), .nRST(nRST), .in_valid(in_valid), .in_ready(in_ready),
    .in_instr(in_instr), .in_pc(in_pc), .rs1_addr(rs1_addr), .rs2_addr(rs2_addr),
    .rs1_data(rs1_data), .rs2_data(rs2_data),
    .rs1_byp_en(rs1_byp_en), .rs1_byp_data(rs1_byp_data),
    .rs2_byp_en(rs2_byp_en), .rs2_byp_data(rs2_byp_data),
    .flush(flush), .out_valid(out_valid), .out_ready(out_ready),
    .out_fu(out_fu), .out_alu_op(out_alu_op), .out_rd(out_rd), .out_wen(out_wen),
    .out_mul_high(out_mul_high), .out_div_rem(out_div_rem), .out_signed(out_signed),
    .out_illegal(out_illegal), .out_port_a(out_port_a), .out_port_b(out_port_b),
    .out_store_data(out_store_data), .out_pc(out_pc)
  );

  function automatic logic [31:0] r_ins(input logic [6:0] f7, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3,
                                        input logic [4:0] rd, input logic [6:0] op);
    return {f7, rs2, rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] i_ins(input logic [11:0] imm, input logic [4:0] rs1,
                                        input logic [2:0] f3, input logic [4:0] rd,
                                        input logic [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] s_ins(input logic [11:0] imm, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'b0100011};
  endfunction

  function automatic logic [31:0] u_ins(input logic [19:0] imm, input logic [4:0] rd,
                                        input logic [6:0] op);
    return {imm, rd, op};
  endfunction

  task automatic add_entry(input string name, input logic [31:0] ins, input int stall,
                           input logic fl, input logic b1en, input logic b2en,
                           input fu_t fu, input alu_op_t op, input logic wen,
                           input logic ill, input logic [2:0] misc);
    t_name[n_ent]  = name;
    t_instr[n_ent] = ins;
    t_pc[n_ent]    = 32'h1000 + 32'(n_ent * 4);
    t_rs1[n_ent]   = $random(seed);
    t_rs2[n_ent]   = $random(seed);
    t_b1[n_ent]    = $random(seed);
    t_b2[n_ent]    = $random(seed);
    t_b1en[n_ent]  = b1en;
    t_b2en[n_ent]  = b2en;
    t_stall[n_ent] = stall;
    t_flush[n_ent] = fl;
    t_fu[n_ent]    = fu;
    t_op[n_ent]    = op;
    t_wen[n_ent]   = wen;
    t_ill[n_ent]   = ill;
    t_misc[n_ent]  = misc;
    n_ent++;
  endtask

  task automatic build_table();
    add_entry("add", r_ins(7'h00, 5'd2, 5'd1, 3'd0, 5'd3, OP), 0, 0, 0, 0,
              FU_ALU, ALU_ADD, 1, 0, 3'b000);
    add_entry("sub", r_ins(7'h20, 5'd4, 5'd5, 3'd0, 5'd6, OP), 0, 0, 0, 0,
              FU_ALU, ALU_SUB, 1, 0, 3'b000);
    add_entry("xori", i_ins(12'hffb, 5'd7, 3'd4, 5'd8, OP_IMM), 0, 0, 0, 0,
              FU_ALU, ALU_XOR, 1, 0, 3'b000);
    add_entry("srai", i_ins({7'h20, 5'd3}, 5'd9, 3'd5, 5'd10, OP_IMM), 0, 0, 0, 0,
              FU_ALU, ALU_SRA, 1, 0, 3'b000);
    add_entry("lui", u_ins(20'habcde, 5'd11, LUI), 0, 0, 0, 0,
              FU_ALU, ALU_ADD, 1, 0, 3'b000);
    add_entry("auipc", u_ins(20'h80001, 5'd12, AUIPC), 0, 0, 0, 0,
              FU_ALU, ALU_ADD, 1, 0, 3'b000);
    add_entry("lw", i_ins(12'hff0, 5'd13, 3'd2, 5'd14, LOAD), 0, 0, 0, 0,
              FU_LSU, ALU_ADD, 1, 0, 3'b001);
    add_entry("lbu", i_ins(12'h07f, 5'd15, 3'd4, 5'd16, LOAD), 0, 0, 0, 0,
              FU_LSU, ALU_ADD, 1, 0, 3'b000);
    add_entry("sw", s_ins(12'hff8, 5'd17, 5'd18, 3'd2), 0, 0, 0, 0,
              FU_LSU, ALU_ADD, 0, 0, 3'b000);
    add_entry("add_byp1", r_ins(7'h00, 5'd20, 5'd19, 3'd0, 5'd21, OP), 0, 0, 1, 0,
              FU_ALU, ALU_ADD, 1, 0, 3'b000);
    add_entry("sw_byp2", s_ins(12'h123, 5'd22, 5'd23, 3'd2), 0, 0, 1, 1,
              FU_LSU, ALU_ADD, 0, 0, 3'b000);
    add_entry("mul", r_ins(7'h01, 5'd2, 5'd1, 3'd0, 5'd24, OP), 0, 0, 0, 0,
              FU_MUL, ALU_ADD, 1, 0, 3'b001);
    // the third add after mul lands on the multiplier's writeback slot
    add_entry("add_a", r_ins(7'h00, 5'd2, 5'd1, 3'd0, 5'd25, OP), 0, 0, 0, 0,
              FU_ALU, ALU_ADD, 1, 0, 3'b000);
    add_entry("add_b", r_ins(7'h00, 5'd2, 5'd1, 3'd0, 5'd26, OP), 0, 0, 0, 0,
              FU_ALU, ALU_ADD, 1, 0, 3'b000);
    add_entry("add_c", r_ins(7'h00, 5'd2, 5'd1, 3'd0, 5'd27, OP), 0, 0, 0, 0,
              FU_ALU, ALU_ADD, 1, 0, 3'b000);
    add_entry("mulh", r_ins(7'h01, 5'd2, 5'd1, 3'd1, 5'd28, OP), 0, 0, 0, 0,
              FU_MUL, ALU_ADD, 1, 0, 3'b101);
    add_entry("divu_zero", r_ins(7'h01, 5'd2, 5'd1, 3'd5, 5'd29, OP), 0, 0, 0, 0,
              FU_DIV, ALU_ADD, 1, 0, 3'b000);
    t_rs2[n_ent-1] = 32'h0;
    add_entry("rem", r_ins(7'h01, 5'd2, 5'd1, 3'd6, 5'd30, OP), 0, 0, 0, 0,
              FU_DIV, ALU_ADD, 1, 0, 3'b011);
    t_rs2[n_ent-1] = 32'h5;
    add_entry("add_hold", r_ins(7'h00, 5'd2, 5'd1, 3'd0, 5'd1, OP), 3, 0, 0, 0,
              FU_ALU, ALU_ADD, 1, 0, 3'b000);
    add_entry("or", r_ins(7'h00, 5'd2, 5'd1, 3'd6, 5'd2, OP), 0, 0, 0, 0,
              FU_ALU, ALU_OR, 1, 0, 3'b000);
    add_entry("and_hold", r_ins(7'h00, 5'd2, 5'd1, 3'd7, 5'd3, OP), 6, 0, 0, 0,
              FU_ALU, ALU_AND, 1, 0, 3'b000);
    add_entry("flushed", r_ins(7'h00, 5'd2, 5'd1, 3'd0, 5'd4, OP), 0, 1, 0, 0,
              FU_ALU, ALU_ADD, 1, 0, 3'b000);
    add_entry("bad_opcode", 32'h0000_007f, 0, 0, 0, 0,
              FU_ALU, ALU_ADD, 0, 1, 3'b000);
    add_entry("bad_funct7", r_ins(7'h10, 5'd2, 5'd1, 3'd0, 5'd5, OP), 0, 0, 0, 0,
              FU_ALU, ALU_ADD, 0, 1, 3'b000);
  endtask

  function automatic logic [31:0] rs1_val(input int i);
    return t_b1en[i] ? t_b1[i] : t_rs1[i];
  endfunction

  function automatic logic [31:0] rs2_val(input int i);
    return t_b2en[i] ? t_b2[i] : t_rs2[i];
  endfunction

  function automatic logic [31:0] exp_a(input int i);
    case (t_instr[i][6:0])
      LUI:     return 32'h0;
      AUIPC:   return t_pc[i];
      default: return rs1_val(i);
    endcase
  endfunction

  function automatic logic [31:0] exp_b(input int i);
    logic [31:0] ins;
    ins = t_instr[i];
    case (ins[6:0])
      OP_IMM, LOAD: return {{20{ins[31]}}, ins[31:20]};
      STORE:        return {{20{ins[31]}}, ins[31:25], ins[11:7]};
      LUI, AUIPC:   return {ins[31:12], 12'h000};
      default:      return rs2_val(i);
    endcase
  endfunction

  function automatic logic is_store(input int i);
    return t_instr[i][6:0] == STORE;
  endfunction

  // writeback slot claimed by the instruction on the fetch inputs
  function automatic logic [wb_window-1:0] slot_of(input int i);
    logic [wb_window-1:0] s;
    logic fast;
    s = '0;
    if (i < 0) begin
      s[lat_alu-1] = 1'b1;
    end else begin
      fast = (exp_a(i) == 32'h8000_0000) || (exp_b(i) == 32'hffff_ffff) ||
             (exp_b(i) == 32'h0);
      case (t_fu[i])
        FU_ALU:  s[lat_alu-1] = 1'b1;
        FU_MUL:  s[lat_mul-1] = 1'b1;
        FU_DIV:  s[(fast ? lat_div_fast : lat_div)-1] = 1'b1;
        default: s = '0;
      endcase
    end
    return s;
  endfunction

  task automatic check_field(input int i, input string field,
                             input logic [31:0] exp, input logic [31:0] act);
    assert (act === exp) else begin
      $display("[FAIL] %s %s expected %h actual %h", t_name[i], field, exp, act);
      err_val++;
    end
  endtask

  task automatic compare_payload(input int i);
    check_field(i, "fu", 32'(t_fu[i]), 32'(out_fu));
    check_field(i, "alu_op", 32'(t_op[i]), 32'(out_alu_op));
    check_field(i, "rd", is_store(i) ? 32'h0 : 32'(t_instr[i][11:7]), 32'(out_rd));
    check_field(i, "wen", 32'(t_wen[i]), 32'(out_wen));
    check_field(i, "misc", 32'(t_misc[i]),
                32'({out_mul_high, out_div_rem, out_signed}));
    check_field(i, "illegal", 32'(t_ill[i]), 32'(out_illegal));
    check_field(i, "port_a", exp_a(i), out_port_a);
    check_field(i, "port_b", exp_b(i), out_port_b);
    check_field(i, "store_data", is_store(i) ? rs2_val(i) : 32'h0, out_store_data);
    check_field(i, "pc", t_pc[i], out_pc);
  endtask

  // one cycle of checks and model update, run on the falling edge
  task automatic step(output bit accepted);
    logic [wb_window-1:0] slot;
    bit exp_ready;
    slot = slot_of(cur);
    exp_ready = ((m_resv & slot) == '0) && (!m_valid || out_ready) && !flush;
    assert (in_ready === exp_ready) else begin
      $display("[FAIL] %s in_ready expected %0b actual %0b",
               cur < 0 ? "idle" : t_name[cur], exp_ready, in_ready);
      err_val++;
    end
    assert (out_valid === m_valid) else begin
      $display("[FAIL] %s out_valid expected %0b actual %0b",
               cur < 0 ? "idle" : t_name[cur], m_valid, out_valid);
      err_val++;
    end
    // register file read addresses come straight from the rs fields
    if (cur >= 0) begin
      check_field(cur, "rs1_addr", 32'(t_instr[cur][19:15]), 32'(rs1_addr));
      check_field(cur, "rs2_addr", 32'(t_instr[cur][24:20]), 32'(rs2_addr));
    end
    if (m_valid && sb.size() > 0) begin
      compare_payload(sb[0]);
    end
    if (m_valid && out_ready) begin
      void'(sb.pop_front());
      transfers++;
    end
    accepted = in_valid && exp_ready;
    m_resv = (accepted ? (m_resv | slot) : m_resv) >> 1;
    if (flush) begin
      m_valid = 1'b0;
      sb.delete();
    end else if (accepted) begin
      m_valid = 1'b1;
      sb.push_back(cur);
    end else if (out_ready) begin
      m_valid = 1'b0;
    end
  endtask

  // execute-side back-pressure, updated on each rising edge
  task automatic drive_ready();
    if (hold_cnt > 0) begin
      out_ready <= 1'b0;
      hold_cnt--;
    end else begin
      out_ready <= 1'b1;
    end
  endtask

  task automatic offer(input int i);
    cur = i;
    in_valid     <= 1'b1;
    in_instr     <= t_instr[i];
    in_pc        <= t_pc[i];
    rs1_data     <= t_rs1[i];
    rs2_data     <= t_rs2[i];
    rs1_byp_en   <= t_b1en[i];
    rs1_byp_data <= t_b1[i];
    rs2_byp_en   <= t_b2en[i];
    rs2_byp_data <= t_b2[i];
    flush        <= t_flush[i];
  endtask

  initial begin
    bit got;
    int n;
    in_valid = 1'b0;
    in_instr = '0;
    in_pc = '0;
    rs1_data = '0;
    rs2_data = '0;
    rs1_byp_en = 1'b0;
    rs1_byp_data = '0;
    rs2_byp_en = 1'b0;
    rs2_byp_data = '0;
    flush = 1'b0;
    out_ready = 1'b1;
    m_resv = '0;
    m_valid = 1'b0;
    cur = -1;
    hold_cnt = 0;
    err_val = 0;
    err_other = 0;
    transfers = 0;
    timed_out = 0;
    seed = 48;
    n_ent = 0;
    build_table();

    n = 0;
    while (nRST !== 1'b1 && n < wait_limit) begin
      @(posedge CLK);
      n++;
    end
    if (nRST !== 1'b1) begin
      $display("reset never released");
      err_other++;
      timed_out = 1;
    end
    @(posedge CLK);

    for (int i = 0; i < n_ent && !timed_out; i++) begin
      offer(i);
      got = 0;
      n = 0;
      while (!got && n < wait_limit) begin
        @(negedge CLK);
        step(got);
        n++;
        @(posedge CLK);
        if (got) begin
          hold_cnt = t_stall[i];
        end
        drive_ready();
        // a flushed offer is dropped after one cycle
        if (t_flush[i]) begin
          break;
        end
      end
      if (!got && !t_flush[i]) begin
        $display("%s was never accepted", t_name[i]);
        err_other++;
        timed_out = 1;
      end
    end

    in_valid <= 1'b0;
    flush <= 1'b0;
    n = 0;
    while (!timed_out && (m_valid || m_resv != '0) && n < wait_limit) begin
      @(negedge CLK);
      step(got);
      n++;
      @(posedge CLK);
      drive_ready();
    end
    if (m_valid) begin
      $display("output did not drain");
      err_other++;
    end
    assert (sb.size() == 0) else begin
      $display("scoreboard still holds %0d items", sb.size());
      err_other++;
    end

    $display("transfers %0d, value errors %0d, other errors %0d",
             transfers, err_val, err_other);
    if (err_val == 0 && err_other == 0 && !timed_out) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule
